// File: axi_bus_pkg.sv
/*
 * system bus definitions
 * beat, address, strobe and ID types of the burst bus,
 * the burst length and the manager IDs
 */
package axi_bus_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] beat_t;
	typedef logic [3:0] strb_t;
	typedef logic [3:0] id_t;

	// beats per cache line
	localparam int BURST_LEN = 4;

	// one ID per manager and direction
	localparam id_t DC_WR_ID = 4'd0;
	localparam id_t DC_RD_ID = 4'd1;
	localparam id_t UART_WR_ID = 4'd2;
	localparam id_t UART_RD_ID = 4'd3;

endpackage

// File: axi_bus_sys.sv
/*
 * bus system top
 * requester-side bus top joined to the burst memory subordinate
 */
`timescale 1ns/1ps

module axi_bus_sys (
	input  logic clk,
	input  logic rst_n,
	input  logic dc_wstart_rq,
	input  axi_bus_pkg::addr_t dc_win_addr,
	input  mngr_pkg::line_t dc_in_wdata,
	input  mngr_pkg::lmask_t dc_in_mask,
	output logic dc_finish_wresp,
	input  logic dc_rstart_rq,
	input  axi_bus_pkg::addr_t dc_rin_addr,
	output mngr_pkg::line_t dc_rdat_m_data,
	output logic dc_rdat_m_valid,
	output logic dc_finish_mrd,
	input  logic uart_wstart_rq,
	input  axi_bus_pkg::addr_t uart_win_addr,
	input  mngr_pkg::line_t uart_in_wdata,
	input  mngr_pkg::lmask_t uart_in_mask,
	output logic uart_finish_wresp,
	input  logic uart_rstart_rq,
	input  axi_bus_pkg::addr_t uart_rin_addr,
	output mngr_pkg::line_t uart_rdat_m_data,
	output logic uart_rdat_m_valid,
	output logic uart_finish_mrd
);

	// subordinate port between bus top and memory
	logic awvalid, awready, wvalid, wready, wlast, bvalid, bready;
	logic arvalid, arready, rvalid, rready, rlast;
	axi_bus_pkg::id_t awid, bid, arid, rid;
	axi_bus_pkg::addr_t awaddr, araddr;
	axi_bus_pkg::beat_t wdata, rdata;
	axi_bus_pkg::strb_t wstrb;

	axi_bus_top i_axi_bus_top (.*);

	axi_mem_sub i_axi_mem_sub (.*);

endmodule

// File: axi_bus_top.sv
/*
 * system bus top
 * write and read managers for the dcache and the uart loader,
 * one arbiter per direction and the mux onto the subordinate port
 */
`timescale 1ns/1ps

module axi_bus_top (
	input  logic clk,
	input  logic rst_n,
	// dcache requester
	input  logic dc_wstart_rq,
	input  axi_bus_pkg::addr_t dc_win_addr,
	input  mngr_pkg::line_t dc_in_wdata,
	input  mngr_pkg::lmask_t dc_in_mask,
	output logic dc_finish_wresp,
	input  logic dc_rstart_rq,
	input  axi_bus_pkg::addr_t dc_rin_addr,
	output mngr_pkg::line_t dc_rdat_m_data,
	output logic dc_rdat_m_valid,
	output logic dc_finish_mrd,
	// uart loader requester
	input  logic uart_wstart_rq,
	input  axi_bus_pkg::addr_t uart_win_addr,
	input  mngr_pkg::line_t uart_in_wdata,
	input  mngr_pkg::lmask_t uart_in_mask,
	output logic uart_finish_wresp,
	input  logic uart_rstart_rq,
	input  axi_bus_pkg::addr_t uart_rin_addr,
	output mngr_pkg::line_t uart_rdat_m_data,
	output logic uart_rdat_m_valid,
	output logic uart_finish_mrd,
	// subordinate port
	output logic awvalid,
	input  logic awready,
	output axi_bus_pkg::id_t awid,
	output axi_bus_pkg::addr_t awaddr,
	output logic wvalid,
	input  logic wready,
	output axi_bus_pkg::beat_t wdata,
	output axi_bus_pkg::strb_t wstrb,
	output logic wlast,
	input  logic bvalid,
	output logic bready,
	input  axi_bus_pkg::id_t bid,
	output logic arvalid,
	input  logic arready,
	output axi_bus_pkg::id_t arid,
	output axi_bus_pkg::addr_t araddr,
	input  logic rvalid,
	output logic rready,
	input  axi_bus_pkg::id_t rid,
	input  axi_bus_pkg::beat_t rdata,
	input  logic rlast
);

	logic [1:0] sel_wt;
	logic [1:0] sel_rd;
	logic dc_req_wt, dc_gnt_wt, dc_awvalid, dc_wvalid, dc_wlast, dc_bready;
	logic dc_req_rd, dc_gnt_rd, dc_arvalid, dc_rready;
	logic uart_req_wt, uart_gnt_wt, uart_awvalid, uart_wvalid, uart_wlast, uart_bready;
	logic uart_req_rd, uart_gnt_rd, uart_arvalid, uart_rready;
	axi_bus_pkg::id_t dc_awid, dc_arid, uart_awid, uart_arid;
	axi_bus_pkg::addr_t dc_awaddr, dc_araddr, uart_awaddr, uart_araddr;
	axi_bus_pkg::beat_t dc_wdata, uart_wdata;
	axi_bus_pkg::strb_t dc_wstrb, uart_wstrb;

	write_channels_mngr #(.REQC_M_ID(axi_bus_pkg::DC_WR_ID)) dc_write_channels_mngr (
		.clk(clk), .rst_n(rst_n), .gnt_rq(dc_gnt_wt), .req_rq(dc_req_wt),
		.awvalid(dc_awvalid), .awready(awready), .awid(dc_awid), .awaddr(dc_awaddr),
		.wvalid(dc_wvalid), .wready(wready), .wdata(dc_wdata), .wstrb(dc_wstrb),
		.wlast(dc_wlast), .bvalid(bvalid), .bready(dc_bready), .bid(bid),
		.wstart_rq(dc_wstart_rq), .win_addr(dc_win_addr), .in_wdata(dc_in_wdata),
		.in_mask(dc_in_mask), .finish_wresp(dc_finish_wresp)
	);

	read_channels_mngr #(.REQC_M_ID(axi_bus_pkg::DC_RD_ID)) dc_read_channels_mngr (
		.clk(clk), .rst_n(rst_n), .gnt_rq(dc_gnt_rd), .req_rq(dc_req_rd),
		.arvalid(dc_arvalid), .arready(arready), .arid(dc_arid), .araddr(dc_araddr),
		.rvalid(rvalid), .rready(dc_rready), .rid(rid), .rdata(rdata), .rlast(rlast),
		.rstart_rq(dc_rstart_rq), .rin_addr(dc_rin_addr), .rdat_m_data(dc_rdat_m_data),
		.rdat_m_valid(dc_rdat_m_valid), .finish_mrd(dc_finish_mrd)
	);

	write_channels_mngr #(.REQC_M_ID(axi_bus_pkg::UART_WR_ID)) uart_write_channels_mngr (
		.clk(clk), .rst_n(rst_n), .gnt_rq(uart_gnt_wt), .req_rq(uart_req_wt),
		.awvalid(uart_awvalid), .awready(awready), .awid(uart_awid), .awaddr(uart_awaddr),
		.wvalid(uart_wvalid), .wready(wready), .wdata(uart_wdata), .wstrb(uart_wstrb),
		.wlast(uart_wlast), .bvalid(bvalid), .bready(uart_bready), .bid(bid),
		.wstart_rq(uart_wstart_rq), .win_addr(uart_win_addr), .in_wdata(uart_in_wdata),
		.in_mask(uart_in_mask), .finish_wresp(uart_finish_wresp)
	);

	read_channels_mngr #(.REQC_M_ID(axi_bus_pkg::UART_RD_ID)) uart_read_channels_mngr (
		.clk(clk), .rst_n(rst_n), .gnt_rq(uart_gnt_rd), .req_rq(uart_req_rd),
		.arvalid(uart_arvalid), .arready(arready), .arid(uart_arid), .araddr(uart_araddr),
		.rvalid(rvalid), .rready(uart_rready), .rid(rid), .rdata(rdata), .rlast(rlast),
		.rstart_rq(uart_rstart_rq), .rin_addr(uart_rin_addr),
		.rdat_m_data(uart_rdat_m_data), .rdat_m_valid(uart_rdat_m_valid),
		.finish_mrd(uart_finish_mrd)
	);

	// grants released by the manager's own finish pulse
	bus_arbiter write_arb (
		.clk(clk), .rst_n(rst_n), .req0(dc_req_wt), .req1(uart_req_wt),
		.finish0(dc_finish_wresp), .finish1(uart_finish_wresp),
		.gnt0(dc_gnt_wt), .gnt1(uart_gnt_wt), .sel(sel_wt)
	);

	bus_arbiter read_arb (
		.clk(clk), .rst_n(rst_n), .req0(dc_req_rd), .req1(uart_req_rd),
		.finish0(dc_finish_mrd), .finish1(uart_finish_mrd),
		.gnt0(dc_gnt_rd), .gnt1(uart_gnt_rd), .sel(sel_rd)
	);

	// selected manager onto the port and zeros while nobody owns it
	assign awvalid = sel_wt[0] ? dc_awvalid : sel_wt[1] ? uart_awvalid : 1'b0;
	assign awid = sel_wt[0] ? dc_awid : sel_wt[1] ? uart_awid : '0;
	assign awaddr = sel_wt[0] ? dc_awaddr : sel_wt[1] ? uart_awaddr : '0;
	assign wvalid = sel_wt[0] ? dc_wvalid : sel_wt[1] ? uart_wvalid : 1'b0;
	assign wdata = sel_wt[0] ? dc_wdata : sel_wt[1] ? uart_wdata : '0;
	assign wstrb = sel_wt[0] ? dc_wstrb : sel_wt[1] ? uart_wstrb : '0;
	assign wlast = sel_wt[0] ? dc_wlast : sel_wt[1] ? uart_wlast : 1'b0;
	assign bready = sel_wt[0] ? dc_bready : sel_wt[1] ? uart_bready : 1'b0;
	assign arvalid = sel_rd[0] ? dc_arvalid : sel_rd[1] ? uart_arvalid : 1'b0;
	assign arid = sel_rd[0] ? dc_arid : sel_rd[1] ? uart_arid : '0;
	assign araddr = sel_rd[0] ? dc_araddr : sel_rd[1] ? uart_araddr : '0;
	assign rready = sel_rd[0] ? dc_rready : sel_rd[1] ? uart_rready : 1'b0;

endmodule

// File: axi_mem_sub.sv
/*
 * burst memory subordinate
 * 256 words serving four-beat write and read bursts,
 * byte writes by strobe, IDs echoed on B and R
 */
`timescale 1ns/1ps

module axi_mem_sub (
	input  logic clk,
	input  logic rst_n,
	input  logic awvalid,
	output logic awready,
	input  axi_bus_pkg::id_t awid,
	input  axi_bus_pkg::addr_t awaddr,
	input  logic wvalid,
	output logic wready,
	input  axi_bus_pkg::beat_t wdata,
	input  axi_bus_pkg::strb_t wstrb,
	input  logic wlast,
	output logic bvalid,
	input  logic bready,
	output axi_bus_pkg::id_t bid,
	input  logic arvalid,
	output logic arready,
	input  axi_bus_pkg::id_t arid,
	input  axi_bus_pkg::addr_t araddr,
	output logic rvalid,
	input  logic rready,
	output axi_bus_pkg::id_t rid,
	output axi_bus_pkg::beat_t rdata,
	output logic rlast
);

	typedef enum logic [1:0] {MW_IDLE, MW_ADDR, MW_DATA, MW_RESP} mw_state_e;
	typedef enum logic [1:0] {MR_IDLE, MR_ADDR, MR_DATA} mr_state_e;

	mw_state_e wstate;
	mr_state_e rstate;
	logic [$clog2(axi_bus_pkg::BURST_LEN)-1:0] rcnt;
	axi_bus_pkg::addr_t waddr_q;
	axi_bus_pkg::addr_t raddr_q;
	axi_bus_pkg::id_t wid_q;
	axi_bus_pkg::id_t rid_q;
	axi_bus_pkg::beat_t mem [0:255];

	// write side
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wstate <= MW_IDLE;
		end else begin
			case (wstate)
				MW_IDLE: if (awvalid) wstate <= MW_ADDR;
				MW_ADDR: wstate <= MW_DATA;
				MW_DATA: if (wvalid && wlast) wstate <= MW_RESP;
				MW_RESP: if (bready) wstate <= MW_IDLE;
				default: wstate <= MW_IDLE;
			endcase
		end
	end

	// read side serves four beats back to back while rready holds
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rstate <= MR_IDLE;
			rcnt <= '0;
		end else begin
			case (rstate)
				MR_IDLE: if (arvalid) rstate <= MR_ADDR;
				MR_ADDR: rstate <= MR_DATA;
				MR_DATA: begin
					if (rready) begin
						rcnt <= rcnt + 1'b1;
						if (rlast)
							rstate <= MR_IDLE;
					end
				end
				default: rstate <= MR_IDLE;
			endcase
		end
	end

	// burst addresses advance one word per beat
	always_ff @(posedge clk) begin
		if (awvalid && awready) begin
			waddr_q <= awaddr;
			wid_q <= awid;
		end else if (wvalid && wready) begin
			waddr_q <= waddr_q + 32'd4;
		end
		if (arvalid && arready) begin
			raddr_q <= araddr;
			rid_q <= arid;
		end else if (rvalid && rready) begin
			raddr_q <= raddr_q + 32'd4;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 256; i++)
				mem[i] <= '0;
		end else if (wvalid && wready) begin
			for (int b = 0; b < 4; b++)
				if (wstrb[b])
					mem[waddr_q[9:2]][8*b +: 8] <= wdata[8*b +: 8];
		end
	end

	assign awready = (wstate == MW_ADDR);
	assign wready = (wstate == MW_DATA);
	assign bvalid = (wstate == MW_RESP);
	assign bid = wid_q;
	assign arready = (rstate == MR_ADDR);
	assign rvalid = (rstate == MR_DATA);
	assign rid = rid_q;
	assign rdata = mem[raddr_q[9:2]];
	assign rlast = rvalid && (rcnt == axi_bus_pkg::BURST_LEN - 1);

endmodule

// File: bus_arbiter.sv
/*
 * two-requester bus arbiter
 * fixed priority with requester 0 first, grant held until
 * the owner's finish pulse
 */
`timescale 1ns/1ps

module bus_arbiter (
	input  logic clk,
	input  logic rst_n,
	input  logic req0,
	input  logic req1,
	input  logic finish0,
	input  logic finish1,
	output logic gnt0,
	output logic gnt1,
	output logic [1:0] sel
);

	mngr_pkg::owner_e owner;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			owner <= mngr_pkg::OWN_NONE;
		end else begin
			case (owner)
				mngr_pkg::OWN_NONE: begin
					if (req0)
						owner <= mngr_pkg::OWN_DC;
					else if (req1)
						owner <= mngr_pkg::OWN_UART;
				end
				mngr_pkg::OWN_DC: begin
					if (finish0)
						owner <= mngr_pkg::OWN_NONE;
				end
				mngr_pkg::OWN_UART: begin
					if (finish1)
						owner <= mngr_pkg::OWN_NONE;
				end
				default: owner <= mngr_pkg::OWN_NONE;
			endcase
		end
	end

	assign gnt0 = (owner == mngr_pkg::OWN_DC);
	assign gnt1 = (owner == mngr_pkg::OWN_UART);
	// bit 0 selects dcache, bit 1 the uart loader
	assign sel = {gnt1, gnt0};

endmodule

// File: bus_trace.txt
# columns: op (write read dwrite dread) requester (dc uart) address line mask expected_line
# dual ops take two lines started in the same cycle; line and mask unused by reads
write  dc   00000040 0123456789abcdeffedcba9876543210 ffff 0
read   dc   00000040 0 0 0123456789abcdeffedcba9876543210
write  uart 00000080 00112233445566778899aabbccddeeff ffff 0
read   uart 00000080 0 0 00112233445566778899aabbccddeeff
read   uart 00000040 0 0 0123456789abcdeffedcba9876543210
write  dc   00000040 aaaaaaaabbbbbbbbccccccccdddddddd 0f05 0
read   dc   00000040 0 0 01234567bbbbbbbbfedcba9876dd32dd
dwrite dc   000000c0 11111111222222223333333344444444 ffff 0
dwrite uart 000000c0 55555555666666667777777788888888 ffff 0
read   dc   000000c0 0 0 55555555666666667777777788888888
dread  dc   00000040 0 0 01234567bbbbbbbbfedcba9876dd32dd
dread  uart 00000080 0 0 00112233445566778899aabbccddeeff
read   uart 00000100 0 0 00000000000000000000000000000000

// File: mngr_pkg.sv
/*
 * bus manager definitions
 * cache line and line mask types, manager and arbiter state encodings
 */
package mngr_pkg;

	typedef logic [127:0] line_t;
	typedef logic [15:0] lmask_t;

	typedef enum logic [2:0] {
		WR_IDLE,
		WR_REQ,
		WR_AW,
		WR_DATA,
		WR_RESP
	} wr_state_e;

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_REQ,
		RD_AR,
		RD_DATA
	} rd_state_e;

	typedef enum logic [1:0] {
		OWN_NONE,
		OWN_DC,
		OWN_UART
	} owner_e;

endpackage

// File: read_channels_mngr.sv
/*
 * read channel manager
 * turns one cache-line read into an AR request, gathers the four
 * R beats with its own ID and hands the line back with a finish pulse
 */
`timescale 1ns/1ps

module read_channels_mngr #(
	parameter axi_bus_pkg::id_t REQC_M_ID = 4'd1
) (
	input  logic clk,
	input  logic rst_n,
	input  logic gnt_rq,
	input  logic arready,
	input  logic rvalid,
	input  axi_bus_pkg::id_t rid,
	input  axi_bus_pkg::beat_t rdata,
	input  logic rlast,
	input  logic rstart_rq,
	input  axi_bus_pkg::addr_t rin_addr,
	output logic req_rq,
	output logic arvalid,
	output axi_bus_pkg::id_t arid,
	output axi_bus_pkg::addr_t araddr,
	output logic rready,
	output mngr_pkg::line_t rdat_m_data,
	output logic rdat_m_valid,
	output logic finish_mrd
);

	mngr_pkg::rd_state_e state;
	logic [$clog2(axi_bus_pkg::BURST_LEN)-1:0] beat_cnt;
	logic beat_ok;
	logic done_q;
	mngr_pkg::line_t line_q;
	axi_bus_pkg::addr_t addr_q;

	// beat accepted and addressed to this manager
	assign beat_ok = rvalid && rready && (rid == REQC_M_ID);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= mngr_pkg::RD_IDLE;
			beat_cnt <= '0;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state)
				mngr_pkg::RD_IDLE: begin
					if (rstart_rq)
						state <= mngr_pkg::RD_REQ;
				end
				mngr_pkg::RD_REQ: begin
					if (gnt_rq)
						state <= mngr_pkg::RD_AR;
				end
				mngr_pkg::RD_AR: begin
					if (arready)
						state <= mngr_pkg::RD_DATA;
				end
				mngr_pkg::RD_DATA: begin
					if (beat_ok) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (rlast) begin
							state <= mngr_pkg::RD_IDLE;
							done_q <= 1'b1;
						end
					end
				end
				default: state <= mngr_pkg::RD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == mngr_pkg::RD_IDLE && rstart_rq)
			addr_q <= {rin_addr[31:4], 4'd0};
		if (beat_ok)
			line_q[32*beat_cnt +: 32] <= rdata;
	end

	assign req_rq = (state == mngr_pkg::RD_REQ);
	assign arvalid = (state == mngr_pkg::RD_AR);
	assign arid = REQC_M_ID;
	assign araddr = addr_q;
	assign rready = (state == mngr_pkg::RD_DATA);

	// line is complete in the cycle after the last beat
	assign rdat_m_data = line_q;
	assign rdat_m_valid = done_q;
	assign finish_mrd = done_q;

endmodule

// File: tb_axi_bus_sys.sv
/*
 * testbench for the bus system
 * replays the line trace on both requesters, checks finish pulses
 * and the lines returned by reads
 */
`timescale 1ns/1ps

module tb_axi_bus_sys;

	localparam int CYCLES_PER_OP = 200;
	localparam int RESET_CYCLES = 10;

	logic clk;
	logic rst_n;
	logic dc_wstart_rq, dc_rstart_rq, uart_wstart_rq, uart_rstart_rq;
	axi_bus_pkg::addr_t dc_win_addr, dc_rin_addr, uart_win_addr, uart_rin_addr;
	mngr_pkg::line_t dc_in_wdata, uart_in_wdata;
	mngr_pkg::lmask_t dc_in_mask, uart_in_mask;
	logic dc_finish_wresp, dc_rdat_m_valid, dc_finish_mrd;
	logic uart_finish_wresp, uart_rdat_m_valid, uart_finish_mrd;
	mngr_pkg::line_t dc_rdat_m_data, uart_rdat_m_data;

	// one entry per trace line
	string op_q[$];
	string who_q[$];
	axi_bus_pkg::addr_t addr_q[$];
	mngr_pkg::line_t line_q[$];
	mngr_pkg::lmask_t mask_q[$];
	mngr_pkg::line_t exp_q[$];
	int n_ops = 0;

	axi_bus_sys i_axi_bus_sys (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_line(input string what, input mngr_pkg::line_t got,
		input mngr_pkg::line_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("mismatch at %0t ns: %s got %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp)
			stop_with_failure($sformatf("mismatch at %0t ns: %s is %b, expected %b",
				$time, what, got, exp));
	endtask

	function automatic logic finish_of(input bit wr, input int side);
		if (wr)
			return (side == 0) ? dc_finish_wresp : uart_finish_wresp;
		return (side == 0) ? dc_finish_mrd : uart_finish_mrd;
	endfunction

	function automatic logic valid_of(input int side);
		return (side == 0) ? dc_rdat_m_valid : uart_rdat_m_valid;
	endfunction

	function automatic mngr_pkg::line_t data_of(input int side);
		return (side == 0) ? dc_rdat_m_data : uart_rdat_m_data;
	endfunction

	// no finish or valid output may be high between operations
	task automatic check_idle();
		check_flag("dc_finish_wresp", dc_finish_wresp, 1'b0);
		check_flag("dc_finish_mrd", dc_finish_mrd, 1'b0);
		check_flag("dc_rdat_m_valid", dc_rdat_m_valid, 1'b0);
		check_flag("uart_finish_wresp", uart_finish_wresp, 1'b0);
		check_flag("uart_finish_mrd", uart_finish_mrd, 1'b0);
		check_flag("uart_rdat_m_valid", uart_rdat_m_valid, 1'b0);
	endtask

	task automatic load_trace();
		int fd;
		int n;
		string text;
		string op;
		string who;
		axi_bus_pkg::addr_t addr;
		mngr_pkg::line_t data;
		mngr_pkg::line_t exp;
		mngr_pkg::lmask_t mask;
		fd = $fopen("bus_trace.txt", "r");
		if (fd == 0) begin
			stop_with_failure("could not open the trace file bus_trace.txt");
		end else begin
			while (!$feof(fd)) begin
				text = "";
				n = $fgets(text, fd);
				// skip comments and empty lines
				if (n > 1 && text.getc(0) != "#") begin
					n = $sscanf(text, "%s %s %h %h %h %h", op, who, addr, data, mask, exp);
					if (n != 6)
						stop_with_failure({"malformed line in the trace file: ", text});
					op_q.push_back(op);
					who_q.push_back(who);
					addr_q.push_back(addr);
					line_q.push_back(data);
					mask_q.push_back(mask);
					exp_q.push_back(exp);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic start_side(input bit wr, input int side, input int k);
		if (wr && side == 0) begin
			dc_wstart_rq = 1'b1;
			dc_win_addr = addr_q[k];
			dc_in_wdata = line_q[k];
			dc_in_mask = mask_q[k];
		end else if (wr) begin
			uart_wstart_rq = 1'b1;
			uart_win_addr = addr_q[k];
			uart_in_wdata = line_q[k];
			uart_in_mask = mask_q[k];
		end else if (side == 0) begin
			dc_rstart_rq = 1'b1;
			dc_rin_addr = addr_q[k];
		end else begin
			uart_rstart_rq = 1'b1;
			uart_rin_addr = addr_q[k];
		end
	endtask

	// one operation or two started in the same cycle
	task automatic run_op(input int k, input bit dual);
		bit wr;
		bit need [2];
		bit seen [2];
		mngr_pkg::line_t exp_line [2];
		int s;
		wr = (op_q[k] == "write" || op_q[k] == "dwrite");
		for (int j = 0; j < 2; j++) begin
			need[j] = 1'b0;
			seen[j] = 1'b0;
			exp_line[j] = '0;
		end
		@(negedge clk);
		for (int j = 0; j < (dual ? 2 : 1); j++) begin
			s = (who_q[k + j] == "dc") ? 0 : 1;
			need[s] = 1'b1;
			exp_line[s] = exp_q[k + j];
			start_side(wr, s, k + j);
		end
		@(negedge clk);
		dc_wstart_rq = 1'b0;
		dc_rstart_rq = 1'b0;
		uart_wstart_rq = 1'b0;
		uart_rstart_rq = 1'b0;
		while (seen[0] != need[0] || seen[1] != need[1]) begin
			@(negedge clk);
			for (int j = 0; j < 2; j++) begin
				string name;
				logic f;
				name = (j == 0) ? "dc" : "uart";
				f = finish_of(wr, j);
				// the other direction has nothing in flight
				check_flag({name, " finish on the idle direction"}, finish_of(!wr, j), 1'b0);
				if (f && need[j] && !seen[j]) begin
					seen[j] = 1'b1;
					if (!wr) begin
						check_flag({name, " rdat_m_valid with finish_mrd"}, valid_of(j), 1'b1);
						check_line({name, " read line"}, data_of(j), exp_line[j]);
					end
				end else begin
					check_flag({name, " extra finish pulse"}, f, 1'b0);
				end
				if (wr || !f)
					check_flag({name, " rdat_m_valid without finish_mrd"},
						valid_of(j), 1'b0);
			end
		end
		// pulses last a single cycle
		@(negedge clk);
		check_idle();
	endtask

	initial begin
		int k;
		rst_n = 1'b0;
		dc_wstart_rq = 1'b0;
		dc_rstart_rq = 1'b0;
		uart_wstart_rq = 1'b0;
		uart_rstart_rq = 1'b0;
		dc_win_addr = '0;
		dc_rin_addr = '0;
		uart_win_addr = '0;
		uart_rin_addr = '0;
		dc_in_wdata = '0;
		uart_in_wdata = '0;
		dc_in_mask = '0;
		uart_in_mask = '0;
		load_trace();
		if (op_q.size() == 0)
			stop_with_failure("the trace file holds no operations");
		n_ops = op_q.size();
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		// quiet outputs while no start arrives
		repeat (5) begin
			@(negedge clk);
			check_idle();
		end
		k = 0;
		while (k < n_ops) begin
			if (op_q[k] == "dwrite" || op_q[k] == "dread") begin
				run_op(k, 1'b1);
				k += 2;
			end else begin
				run_op(k, 1'b0);
				k += 1;
			end
		end
		$display("Simulation completed successfully");
		$finish;
	end

	// watchdog sized by the number of trace operations
	initial begin
		wait (n_ops > 0);
		repeat (CYCLES_PER_OP * n_ops + RESET_CYCLES + 10) @(posedge clk);
		stop_with_failure("watchdog expired because a finish pulse never arrived");
	end

endmodule

// File: vlog.f
axi_bus_pkg.sv
mngr_pkg.sv
write_channels_mngr.sv
read_channels_mngr.sv
bus_arbiter.sv
axi_bus_top.sv
axi_mem_sub.sv
axi_bus_sys.sv
tb_axi_bus_sys.sv

// File: write_channels_mngr.sv
/*
 * write channel manager
 * turns one cache-line write into an AW request and a four-beat
 * W burst, then waits for the B response carrying its own ID
 */
`timescale 1ns/1ps

module write_channels_mngr #(
	parameter axi_bus_pkg::id_t REQC_M_ID = 4'd0
) (
	input  logic clk,
	input  logic rst_n,
	input  logic gnt_rq,
	input  logic awready,
	input  logic wready,
	input  logic bvalid,
	input  axi_bus_pkg::id_t bid,
	input  logic wstart_rq,
	input  axi_bus_pkg::addr_t win_addr,
	input  mngr_pkg::line_t in_wdata,
	input  mngr_pkg::lmask_t in_mask,
	output logic req_rq,
	output logic awvalid,
	output axi_bus_pkg::id_t awid,
	output axi_bus_pkg::addr_t awaddr,
	output logic wvalid,
	output axi_bus_pkg::beat_t wdata,
	output axi_bus_pkg::strb_t wstrb,
	output logic wlast,
	output logic bready,
	output logic finish_wresp
);

	mngr_pkg::wr_state_e state;
	logic [$clog2(axi_bus_pkg::BURST_LEN)-1:0] beat_cnt;
	mngr_pkg::line_t line_q;
	mngr_pkg::lmask_t mask_q;
	axi_bus_pkg::addr_t addr_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= mngr_pkg::WR_IDLE;
			beat_cnt <= '0;
			finish_wresp <= 1'b0;
		end else begin
			finish_wresp <= 1'b0;
			case (state)
				mngr_pkg::WR_IDLE: begin
					if (wstart_rq)
						state <= mngr_pkg::WR_REQ;
				end
				mngr_pkg::WR_REQ: begin
					if (gnt_rq)
						state <= mngr_pkg::WR_AW;
				end
				mngr_pkg::WR_AW: begin
					if (awready)
						state <= mngr_pkg::WR_DATA;
				end
				mngr_pkg::WR_DATA: begin
					// counter wraps to zero after the last beat
					if (wready) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (wlast)
							state <= mngr_pkg::WR_RESP;
					end
				end
				mngr_pkg::WR_RESP: begin
					if (bvalid && bid == REQC_M_ID) begin
						state <= mngr_pkg::WR_IDLE;
						finish_wresp <= 1'b1;
					end
				end
				default: state <= mngr_pkg::WR_IDLE;
			endcase
		end
	end

	// line, mask and line-aligned address taken at the start pulse
	always_ff @(posedge clk) begin
		if (state == mngr_pkg::WR_IDLE && wstart_rq) begin
			line_q <= in_wdata;
			mask_q <= in_mask;
			addr_q <= {win_addr[31:4], 4'd0};
		end
	end

	assign req_rq = (state == mngr_pkg::WR_REQ);
	assign awvalid = (state == mngr_pkg::WR_AW);
	assign awid = REQC_M_ID;
	assign awaddr = addr_q;

	// beat k is line word k with mask nibble k
	assign wvalid = (state == mngr_pkg::WR_DATA);
	assign wdata = line_q[32*beat_cnt +: 32];
	assign wstrb = mask_q[4*beat_cnt +: 4];
	assign wlast = wvalid && (beat_cnt == axi_bus_pkg::BURST_LEN - 1);

	assign bready = (state == mngr_pkg::WR_RESP);

endmodule
